// ==== filelist.f ====
+incdir+include
source/overlay_pkg.sv
source/video_timing.sv
source/glyph_rom.sv
source/glyph_rom_arbiter.sv
source/menu_label_render.sv
source/banner_scroll_render.sv
source/overlay_mixer.sv
source/menu_overlay_top.sv
tests/tb_menu_overlay.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the menu overlay testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_menu_overlay \
    -f filelist.f \
    -o sim_menu_overlay

./obj_dir/sim_menu_overlay 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"

// ==== tests/tb_menu_overlay.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "overlay_defs.svh"

module tb_menu_overlay
    import overlay_pkg::*;
();

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int PIPE_DELAY   = 4;     // Timing register plus three mixer stages.
    localparam int RUN_FRAMES   = 42;    // Enough for the scroll offset to wrap.
    localparam int GLYPH_W      = $bits(glyph_row_t);

    logic        pix_clk = 1'b0;
    logic        arst_n;
    logic        de_out;
    logic        hs_out;
    logic        vs_out;
    pixel_t      rgb_out;

    logic [31:0] lcg_state = 32'hc4711a9e;
    int          since_rel;              // Rising clock edges seen with reset released.
    int          de_run;
    int          line_count;
    logic        de_prev;
    logic        vs_prev;

    menu_overlay_top menu_overlay_top_inst (
        .pix_clk (pix_clk),
        .arst_n  (arst_n),
        .de_out  (de_out),
        .hs_out  (hs_out),
        .vs_out  (vs_out),
        .rgb_out (rgb_out)
    );

    always #5 pix_clk = ~pix_clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Column c of glyph row r is lit when (3r + c) mod 7 < 3.
    function automatic logic rom_bit(input int row, input int col);
        return ((3 * row + col) % 7) < 3;
    endfunction

    function automatic pixel_t expected_colour(input int h, input int v, input int frame);
        int     box_x [3];
        int     k;
        int     col;
        pixel_t colour;
        box_x[0] = `BOX0_X;
        box_x[1] = `BOX1_X;
        box_x[2] = `BOX2_X;
        colour   = `BG_COLOUR;
        if ((v >= `BOX_Y0) && (v < `BOX_Y0 + `BOX_H))
        begin
            for (k = 0; k < 3; k++)
            begin
                if ((h >= box_x[k]) && (h < box_x[k] + `BOX_W))
                begin
                    if (rom_bit((v - `BOX_Y0) + k * `BOX_H, h - box_x[k]))
                        colour = `MENU_FG;
                end
            end
        end
        else if ((v >= `BANNER_Y0) && (v < `BANNER_Y0 + `BANNER_H))
        begin
            col = (h + frame % GLYPH_W) % GLYPH_W;   // Offset steps once per frame.
            if (rom_bit(`BANNER_ROW0 + (v - `BANNER_Y0), col))
                colour = `BANNER_FG;
        end
        return colour;
    endfunction

    task automatic report_failure();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s is %0b, expected %0b", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic sample_outputs();
        int     i;
        int     h;
        int     v;
        logic   exp_de;
        logic   exp_hs;
        logic   exp_vs;
        pixel_t exp_rgb;
        exp_de  = 1'b0;
        exp_hs  = 1'b0;
        exp_vs  = 1'b0;
        exp_rgb = `BLANK_COLOUR;
        if (arst_n && (since_rel >= PIPE_DELAY))
        begin
            i      = since_rel - PIPE_DELAY;
            h      = i % `H_TOTAL;
            v      = (i / `H_TOTAL) % `V_TOTAL;
            exp_de = (h < `H_ACT) && (v < `V_ACT);
            exp_hs = (h >= `HS_START) && (h < `HS_START + `HS_LEN);
            exp_vs = (v >= `VS_START) && (v < `VS_START + `VS_LEN);
            if (exp_de)
                exp_rgb = expected_colour(h, v, i / FRAME_CYCLES);
        end
        check_strobe("de_out", de_out, exp_de);
        check_strobe("hs_out", hs_out, exp_hs);
        check_strobe("vs_out", vs_out, exp_vs);
        check_pixel("rgb_out", rgb_out, exp_rgb);

        if (!arst_n)
        begin
            de_run     = 0;
            line_count = 0;
        end
        else
        begin
            if (de_out)
                de_run++;
            if (de_prev && !de_out)
            begin
                check_count("de_out cycles per line", de_run, `H_ACT);
                de_run = 0;
                line_count++;
            end
            if (vs_out && !vs_prev)
            begin
                check_count("active lines per frame", line_count, `V_ACT);
                line_count = 0;
            end
        end
        de_prev = de_out;
        vs_prev = vs_out;
    endtask

    // Outputs are sampled mid-cycle, then reset is driven for the next edge.
    task automatic run_cycle(input logic rst_level);
        @(negedge pix_clk);
        sample_outputs();
        arst_n = rst_level;
        if (rst_level)
            since_rel++;
        else
            since_rel = 0;
    endtask

    task automatic apply_reset(input int cycles);
        repeat (cycles) run_cycle(1'b0);
    endtask

    task automatic wait_de_rise(input int limit);
        int n;
        n = 0;
        while (!de_out)
        begin
            if (n >= limit)
            begin
                $display("Timeout: de_out did not go high within %0d cycles", limit);
                report_failure();
            end
            run_cycle(1'b1);
            n++;
        end
    endtask

    task automatic wait_vs_rise(input int limit);
        int   n;
        logic prev;
        logic rose;
        n    = 0;
        rose = 1'b0;
        while (!rose)
        begin
            if (n >= limit)
            begin
                $display("Timeout: no vs_out pulse within %0d cycles", limit);
                report_failure();
            end
            prev = vs_out;
            run_cycle(1'b1);
            rose = vs_out && !prev;
            n++;
        end
    endtask

    task automatic run_frames(input int count);
        repeat (count) wait_vs_rise(2 * FRAME_CYCLES);
    endtask

    initial
    begin
        int rst_len;
        int mid_point;
        arst_n     = 1'b0;
        since_rel  = 0;
        de_run     = 0;
        line_count = 0;
        de_prev    = 1'b0;
        vs_prev    = 1'b0;

        rst_len = 3 + int'((next_rand() >> 8) % 32'd6);
        apply_reset(rst_len);
        wait_de_rise(2 * FRAME_CYCLES);
        run_frames(RUN_FRAMES);

        // Second reset lands somewhere inside a frame.
        mid_point = int'((next_rand() >> 8) % 32'(FRAME_CYCLES));
        repeat (mid_point) run_cycle(1'b1);
        rst_len = 3 + int'((next_rand() >> 8) % 32'd6);
        apply_reset(rst_len);
        wait_de_rise(2 * FRAME_CYCLES);
        run_frames(RUN_FRAMES);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/menu_overlay_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module menu_overlay_top
    import overlay_pkg::*;
(
    input  logic   pix_clk,
    input  logic   arst_n,
    output logic   de_out,
    output logic   hs_out,
    output logic   vs_out,
    output pixel_t rgb_out
);

    pos_x_t      act_x;
    pos_y_t      act_y;
    logic        de;
    logic        hs;
    logic        vs;
    logic        menu_req;
    logic        banner_req;
    logic        menu_gnt;
    logic        banner_gnt;
    glyph_addr_t menu_addr;
    glyph_addr_t banner_addr;
    glyph_addr_t rom_addr;
    glyph_row_t  rd_data;
    logic        menu_on;
    logic        banner_on;
    pixel_t      menu_pixel;
    pixel_t      banner_pixel;

    video_timing video_timing_inst (
        .pix_clk (pix_clk),
        .arst_n  (arst_n),
        .act_x   (act_x),
        .act_y   (act_y),
        .de      (de),
        .hs      (hs),
        .vs      (vs)
    );

    glyph_rom glyph_rom_inst (
        .pix_clk (pix_clk),
        .addr    (rom_addr),
        .rd_data (rd_data)
    );

    glyph_rom_arbiter glyph_rom_arbiter_inst (
        .pix_clk     (pix_clk),
        .arst_n      (arst_n),
        .menu_req    (menu_req),
        .menu_addr   (menu_addr),
        .banner_req  (banner_req),
        .banner_addr (banner_addr),
        .menu_gnt    (menu_gnt),
        .banner_gnt  (banner_gnt),
        .rom_addr    (rom_addr)
    );

    menu_label_render menu_label_render_inst (
        .pix_clk   (pix_clk),
        .arst_n    (arst_n),
        .act_x     (act_x),
        .act_y     (act_y),
        .de        (de),
        .menu_gnt  (menu_gnt),
        .rd_data   (rd_data),
        .menu_req  (menu_req),
        .menu_addr (menu_addr),
        .text_on   (menu_on),
        .pixel     (menu_pixel)
    );

    banner_scroll_render banner_scroll_render_inst (
        .pix_clk     (pix_clk),
        .arst_n      (arst_n),
        .act_x       (act_x),
        .act_y       (act_y),
        .de          (de),
        .vs          (vs),
        .banner_gnt  (banner_gnt),
        .rd_data     (rd_data),
        .banner_req  (banner_req),
        .banner_addr (banner_addr),
        .text_on     (banner_on),
        .pixel       (banner_pixel)
    );

    overlay_mixer overlay_mixer_inst (
        .pix_clk      (pix_clk),
        .arst_n       (arst_n),
        .de           (de),
        .hs           (hs),
        .vs           (vs),
        .menu_on      (menu_on),
        .menu_pixel   (menu_pixel),
        .banner_on    (banner_on),
        .banner_pixel (banner_pixel),
        .de_out       (de_out),
        .hs_out       (hs_out),
        .vs_out       (vs_out),
        .rgb_out      (rgb_out)
    );

endmodule

`default_nettype wire

// ==== source/overlay_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "overlay_defs.svh"

module overlay_mixer
    import overlay_pkg::*;
(
    input  logic   pix_clk,
    input  logic   arst_n,
    input  logic   de,
    input  logic   hs,
    input  logic   vs,
    input  logic   menu_on,
    input  pixel_t menu_pixel,
    input  logic   banner_on,
    input  pixel_t banner_pixel,
    output logic   de_out,
    output logic   hs_out,
    output logic   vs_out,
    output pixel_t rgb_out
);

    // Three stages, one per renderer pipeline stage.
    logic [2:0] de_sr;
    logic [2:0] hs_sr;
    logic [2:0] vs_sr;

    always_ff @(posedge pix_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            de_sr <= '0;
            hs_sr <= '0;
            vs_sr <= '0;
        end
        else
        begin
            de_sr <= {de_sr[1:0], de};
            hs_sr <= {hs_sr[1:0], hs};
            vs_sr <= {vs_sr[1:0], vs};
        end
    end

    assign de_out = de_sr[2];
    assign hs_out = hs_sr[2];
    assign vs_out = vs_sr[2];

    always_comb
    begin
        if (!de_out)
            rgb_out = `BLANK_COLOUR;
        else if (menu_on)
            rgb_out = menu_pixel;
        else if (banner_on)
            rgb_out = banner_pixel;
        else
            rgb_out = `BG_COLOUR;
    end

    // Text coming out of the renderers must line up with the delayed data enable.
    text_in_active: assert property (@(posedge pix_clk) disable iff (!arst_n)
        (menu_on || banner_on) |-> de_out)
        else $error("renderer text arrived outside the active area");

endmodule

`default_nettype wire

// ==== source/banner_scroll_render.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "overlay_defs.svh"

module banner_scroll_render
    import overlay_pkg::*;
(
    input  logic        pix_clk,
    input  logic        arst_n,
    input  pos_x_t      act_x,
    input  pos_y_t      act_y,
    input  logic        de,
    input  logic        vs,
    input  logic        banner_gnt,
    input  glyph_row_t  rd_data,
    output logic        banner_req,
    output glyph_addr_t banner_addr,
    output logic        text_on,
    output pixel_t      pixel
);

    localparam int GLYPH_W = $bits(glyph_row_t);

    logic       vs_q;
    logic [5:0] offset;
    logic       in_band;
    logic [8:0] col_sum;
    logic [5:0] col_q;
    logic [5:0] col_q2;
    logic       gnt_q;
    logic       bit_on;

    assign in_band = de && (act_y >= `BANNER_Y0) && (act_y < `BANNER_Y0 + `BANNER_H);
    assign col_sum = {1'b0, act_x} + {3'b000, offset};
    assign bit_on  = rd_data[GLYPH_W - 1 - col_q2];

    always_ff @(posedge pix_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            vs_q       <= 1'b0;
            offset     <= '0;
            banner_req <= 1'b0;
            gnt_q      <= 1'b0;
            text_on    <= 1'b0;
        end
        else
        begin
            vs_q <= vs;
            if (vs && !vs_q)
                offset <= (offset == 6'(GLYPH_W - 1)) ? 6'd0 : offset + 6'd1; // One column a frame.
            banner_req <= in_band;
            gnt_q      <= banner_gnt;
            text_on    <= gnt_q && bit_on;
        end
    end

    always_ff @(posedge pix_clk)
    begin
        banner_addr <= glyph_addr_t'(`BANNER_ROW0 + (act_y - `BANNER_Y0));
        col_q       <= 6'(col_sum % 9'(GLYPH_W));
        col_q2      <= col_q;
        pixel       <= bit_on ? `BANNER_FG : `BLANK_COLOUR;
    end

endmodule

`default_nettype wire

// ==== source/menu_label_render.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "overlay_defs.svh"

module menu_label_render
    import overlay_pkg::*;
(
    input  logic        pix_clk,
    input  logic        arst_n,
    input  pos_x_t      act_x,
    input  pos_y_t      act_y,
    input  logic        de,
    input  logic        menu_gnt,
    input  glyph_row_t  rd_data,
    output logic        menu_req,
    output glyph_addr_t menu_addr,
    output logic        text_on,
    output pixel_t      pixel
);

    localparam int GLYPH_MSB = $bits(glyph_row_t) - 1;

    logic       hit;
    logic [1:0] box_idx;
    pos_x_t     box_x;
    logic [5:0] col_q;
    logic [5:0] col_q2;
    logic       gnt_q;
    logic       bit_on;

    always_comb
    begin
        hit     = 1'b0;
        box_idx = 2'd0;
        box_x   = pos_x_t'(`BOX0_X);
        if (de && (act_y >= `BOX_Y0) && (act_y < `BOX_Y0 + `BOX_H))
        begin
            if ((act_x >= `BOX0_X) && (act_x < `BOX0_X + `BOX_W))
            begin
                hit = 1'b1;
            end
            else if ((act_x >= `BOX1_X) && (act_x < `BOX1_X + `BOX_W))
            begin
                hit     = 1'b1;
                box_idx = 2'd1;
                box_x   = pos_x_t'(`BOX1_X);
            end
            else if ((act_x >= `BOX2_X) && (act_x < `BOX2_X + `BOX_W))
            begin
                hit     = 1'b1;
                box_idx = 2'd2;
                box_x   = pos_x_t'(`BOX2_X);
            end
        end
    end

    assign bit_on = rd_data[GLYPH_MSB - col_q2];

    always_ff @(posedge pix_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            menu_req <= 1'b0;
            gnt_q    <= 1'b0;
            text_on  <= 1'b0;
        end
        else
        begin
            menu_req <= hit;
            gnt_q    <= menu_gnt;          // Tells us the next ROM word is ours.
            text_on  <= gnt_q && bit_on;
        end
    end

    // Each box owns twelve consecutive ROM rows.
    always_ff @(posedge pix_clk)
    begin
        menu_addr <= glyph_addr_t'((act_y - `BOX_Y0) + box_idx * `BOX_H);
        col_q     <= 6'(act_x - box_x);
        col_q2    <= col_q;
        pixel     <= bit_on ? `MENU_FG : `BLANK_COLOUR;
    end

endmodule

`default_nettype wire

// ==== source/glyph_rom_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module glyph_rom_arbiter
    import overlay_pkg::*;
(
    input  logic        pix_clk,
    input  logic        arst_n,
    input  logic        menu_req,
    input  glyph_addr_t menu_addr,
    input  logic        banner_req,
    input  glyph_addr_t banner_addr,
    output logic        menu_gnt,
    output logic        banner_gnt,
    output glyph_addr_t rom_addr
);

    // Fixed priority with the menu renderer first. Grants are given in the cycle of the request.
    assign menu_gnt   = menu_req;
    assign banner_gnt = banner_req && !menu_req;

    always_comb
    begin
        if (menu_req)
            rom_addr = menu_addr;
        else
            rom_addr = banner_addr;
    end

    // The label boxes and the banner band sit on different lines, so the
    // renderers should never ask for the ROM in the same cycle.
    no_rom_conflict: assert property (@(posedge pix_clk) disable iff (!arst_n)
        !(menu_req && banner_req))
        else $error("menu and banner renderers requested the glyph ROM together");

endmodule

`default_nettype wire

// ==== source/glyph_rom.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "overlay_defs.svh"

module glyph_rom
    import overlay_pkg::*;
(
    input  logic        pix_clk,
    input  glyph_addr_t addr,
    output glyph_row_t  rd_data
);

    localparam int GLYPH_MSB = $bits(glyph_row_t) - 1;

    glyph_row_t rom [0:`ROM_ROWS-1];

    // The stand-in font is a diagonal stripe pattern that shifts by three columns per row.
    initial
    begin
        for (int r = 0; r < `ROM_ROWS; r++)
        begin
            for (int c = 0; c <= GLYPH_MSB; c++)
            begin
                rom[r][GLYPH_MSB - c] = (((3 * r + c) % 7) < 3);
            end
        end
    end

    always_ff @(posedge pix_clk)
    begin
        rd_data <= rom[addr];
    end

endmodule

`default_nettype wire

// ==== source/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "overlay_defs.svh"

module video_timing
    import overlay_pkg::*;
(
    input  logic   pix_clk,
    input  logic   arst_n,
    output pos_x_t act_x,
    output pos_y_t act_y,
    output logic   de,
    output logic   hs,
    output logic   vs
);

    pos_x_t h_cnt;
    pos_y_t v_cnt;
    logic   line_end;

    assign line_end = (h_cnt == pos_x_t'(`H_TOTAL - 1));

    always_ff @(posedge pix_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (line_end)
        begin
            h_cnt <= '0;
            if (v_cnt == pos_y_t'(`V_TOTAL - 1))
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 6'd1;
        end
        else
        begin
            h_cnt <= h_cnt + 8'd1;
        end
    end

    // All five scan outputs come out of one register stage so they stay aligned.
    always_ff @(posedge pix_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            act_x <= '0;
            act_y <= '0;
            de    <= 1'b0;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end
        else
        begin
            act_x <= h_cnt;
            act_y <= v_cnt;
            de    <= (h_cnt < `H_ACT) && (v_cnt < `V_ACT);
            hs    <= (h_cnt >= `HS_START) && (h_cnt < `HS_START + `HS_LEN);
            vs    <= (v_cnt >= `VS_START) && (v_cnt < `VS_START + `VS_LEN); // Whole lines.
        end
    end

    act_x_in_line: assert property (@(posedge pix_clk) disable iff (!arst_n)
        act_x < `H_TOTAL)
        else $error("act_x ran past the end of the line");

endmodule

`default_nettype wire

// ==== source/overlay_pkg.sv ====
`default_nettype none

package overlay_pkg;

    // RGB565 pixel.
    typedef logic [15:0] pixel_t;

    // One glyph ROM row; column c is held in bit 39 - c.
    typedef logic [39:0] glyph_row_t;

    typedef logic [5:0] glyph_addr_t;

    typedef logic [7:0] pos_x_t;
    typedef logic [5:0] pos_y_t;

endpackage

`default_nettype wire

// ==== include/overlay_defs.svh ====
`ifndef OVERLAY_DEFS_SVH
`define OVERLAY_DEFS_SVH

// Reduced test frame with short blanking on both axes.
`define H_ACT        160
`define H_TOTAL      180
`define V_ACT        60
`define V_TOTAL      64
`define HS_START     165
`define HS_LEN       5
`define VS_START     61
`define VS_LEN       2

`define BOX_W        40
`define BOX_H        12
`define BOX_Y0       20
`define BOX0_X       8
`define BOX1_X       60
`define BOX2_X       112

`define BANNER_Y0    44
`define BANNER_H     8
`define BANNER_ROW0  36    // Banner glyphs sit after the three label boxes.

`define ROM_ROWS     44

`define MENU_FG      16'hffff
`define BANNER_FG    16'hffe0
`define BG_COLOUR    16'h0010
`define BLANK_COLOUR 16'h0000

`endif
